//--- filelist.f
hdl/stretchPkg.sv
hdl/syncFifo.sv
hdl/chunkRequestMapper.sv
hdl/upstreamPixelTracker.sv
hdl/interpolationStage.sv
hdl/videoHorizontalStretch.sv
tests/stretchTb.sv

//--- hdl/chunkRequestMapper.sv
//####################################################################
// Chunk request mapper: walks each downstream chunk, maps every output
// column to a source coordinate and issues filtered upstream requests
//####################################################################
`timescale 1ns/1ps

module chunkRequestMapper
    import stretchPkg::*;
#(
    parameter int chunkBits = 5,
    localparam int chunkNumBits = hActiveBits - chunkBits,
    localparam int requestBits = vActiveBits + chunkNumBits
) (
    input logic scalerClock,
    input logic reset,
    input logic [scaleBits-1:0] hShrinkFactor,
    input logic downstreamRequestEmpty,
    input logic [requestBits-1:0] downstreamRequestData,
    output logic downstreamRequestRead,
    input logic upstreamRequestRead,
    output logic upstreamRequestEmpty,
    output logic [requestBits-1:0] upstreamRequestData,
    output logic chunkTagWrite,
    output logic [chunkNumBits-1:0] chunkTag,
    input logic chunkTagFull,
    output logic coordWrite,
    output sourceCoord coord,
    input logic coordFull
);
    localparam int coordBits = $bits(sourceCoord);

    typedef enum logic {stateIdle, stateWalk} mapState;

    mapState state;
    logic [requestBits-1:0] currentRequest;
    logic [chunkBits-1:0] pixelCount;
    logic [requestBits-1:0] lastRequest;
    logic [requestBits-1:0] previousRequest;
    logic lastValid;
    logic previousValid;
    logic upstreamQueueFull;
    logic [hActiveBits-1:0] outputColumn;
    logic [requestBits-1:0] thisChunkRequest;
    logic [requestBits-1:0] nextChunkRequest;
    logic [requestBits-1:0] issuedRequest;
    logic needThisChunk;
    logic needNextChunk;
    logic advance;

    // Output column is the downstream chunk number followed by the pixel count
    assign outputColumn = {currentRequest[chunkNumBits-1:0], pixelCount};

    // Pixel centres map to column * shrink + shrink / 2, which fits 17 bits
    assign coord = sourceCoord'(coordBits'(outputColumn) * coordBits'(hShrinkFactor)
        + coordBits'(hShrinkFactor[scaleBits-1:1]));

    // Upstream requests reuse the row and swap in the source chunk number
    assign thisChunkRequest = {currentRequest[requestBits-1:chunkNumBits],
        coord.column[hActiveBits-1:chunkBits]};
    assign nextChunkRequest = {currentRequest[requestBits-1:chunkNumBits],
        coord.column[hActiveBits-1:chunkBits] + 1'b1};

    // A chunk among the last two issued is already on its way
    assign needThisChunk = !((lastValid && lastRequest == thisChunkRequest)
        || (previousValid && previousRequest == thisChunkRequest));

    // Blending off the last column of a chunk also needs the first pixel of the next one
    assign needNextChunk = (coord.fraction != '0) && (&coord.column[chunkBits-1:0])
        && !((lastValid && lastRequest == nextChunkRequest)
        || (previousValid && previousRequest == nextChunkRequest));

    // Any full queue stalls the whole column for this cycle
    assign advance = (state == stateWalk) && !coordFull && !chunkTagFull && !upstreamQueueFull;
    assign coordWrite = advance;
    assign chunkTagWrite = advance && (needThisChunk || needNextChunk);
    assign issuedRequest = needThisChunk ? thisChunkRequest : nextChunkRequest;
    assign chunkTag = issuedRequest[chunkNumBits-1:0];

    // Upstream request queue, read directly by the upstream stage
    syncFifo #(
        .dataWidth(requestBits),
        .addrWidth(chunkNumBits)
    ) upstreamRequestQueue (
        .scalerClock(scalerClock),
        .reset(reset),
        .writeEnable(chunkTagWrite),
        .writeData(issuedRequest),
        .readEnable(upstreamRequestRead),
        .full(upstreamQueueFull),
        .empty(upstreamRequestEmpty),
        .readData(upstreamRequestData)
    );

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            state <= stateIdle;
            downstreamRequestRead <= 1'b0;
            currentRequest <= '0;
            pixelCount <= '0;
            lastRequest <= '0;
            previousRequest <= '0;
            lastValid <= 1'b0;
            previousValid <= 1'b0;
        end else begin
            downstreamRequestRead <= 1'b0;
            case (state)
                stateIdle: begin
                    // Request memory only filters within one downstream chunk
                    lastValid <= 1'b0;
                    previousValid <= 1'b0;
                    // The head word is valid now and the read pulse pops it next cycle
                    if (!downstreamRequestEmpty) begin
                        downstreamRequestRead <= 1'b1;
                        currentRequest <= downstreamRequestData;
                        pixelCount <= '0;
                        state <= stateWalk;
                    end
                end
                stateWalk: begin
                    if (chunkTagWrite) begin
                        lastRequest <= issuedRequest;
                        previousRequest <= lastRequest;
                        lastValid <= 1'b1;
                        previousValid <= lastValid;
                    end
                    if (advance) begin
                        pixelCount <= pixelCount + 1'b1;
                        // Back to idle once the last column of the chunk is written
                        if (&pixelCount) begin
                            state <= stateIdle;
                        end
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

endmodule

//--- hdl/interpolationStage.sv
//####################################################################
// Interpolation stage: holds the oldest pending coordinate, advances
// the pixel window until it covers it and writes the blended pixel
//####################################################################
`timescale 1ns/1ps

module interpolationStage
    import stretchPkg::*;
(
    input logic scalerClock,
    input logic reset,
    input logic coordWrite,
    input sourceCoord coord,
    output logic coordFull,
    input pixelWindow window,
    input logic pixelReady,
    output logic windowAdvance,
    input logic responseFull,
    output logic responseWrite,
    output pixelWord responseData
);
    localparam int coordQueueBits = 5;

    sourceCoord headCoord;
    logic coordEmpty;
    logic coordRead;
    sourceCoord heldCoord;
    logic holdValid;
    logic covered;

    // Pending coordinates, one per output column, in output order
    syncFifo #(
        .dataWidth($bits(sourceCoord)),
        .addrWidth(coordQueueBits)
    ) coordQueue (
        .scalerClock(scalerClock),
        .reset(reset),
        .writeEnable(coordWrite),
        .writeData(coord),
        .readEnable(coordRead),
        .full(coordFull),
        .empty(coordEmpty),
        .readData(headCoord)
    );

    // A whole column needs only the left pixel, otherwise both neighbours must be present
    assign covered = holdValid && window.windowValid && (window.leftColumn == heldCoord.column)
        && (heldCoord.fraction == '0 || window.rightColumn == heldCoord.column + 1'b1);

    assign responseWrite = covered && !responseFull;
    assign responseData = blendPixels(window.leftColor, window.rightColor, heldCoord.fraction);

    // Pull in pixels only while a coordinate waits and the window falls short
    assign windowAdvance = holdValid && !covered && pixelReady;

    // Refill the hold when it is empty or its coordinate is served this cycle
    assign coordRead = !coordEmpty && (!holdValid || responseWrite);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            heldCoord <= '0;
            holdValid <= 1'b0;
        end else if (coordRead) begin
            heldCoord <= headCoord;
            holdValid <= 1'b1;
        end else if (responseWrite) begin
            holdValid <= 1'b0;
        end
    end

    // Under back-pressure the window must not move, so the pending output waits unchanged
    assert property (@(posedge scalerClock) disable iff (reset)
        responseFull && covered |=> covered && $stable(responseData))
        else $error("pending output lost under responseFull");

endmodule

//--- hdl/stretchPkg.sv
//####################################################################
// Horizontal stretch shared definitions: sizes, RGB565 pixel types,
// the two-pixel window layout and the per-channel blend
//####################################################################
package stretchPkg;

    // Active video spans at most 2048 columns and 2048 rows
    localparam int hActiveBits = 11;
    localparam int vActiveBits = 11;

    // Coordinates and the shrink factor carry six fraction bits
    localparam int scaleFractionBits = 6;
    localparam int scaleBits = scaleFractionBits + 1;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } pixelRgb;

    // Queues and ports move the raw word and the blend reads the channels
    typedef union packed {
        logic [15:0] raw;
        pixelRgb rgb;
    } pixelWord;

    // Position of one output pixel in upstream column units
    typedef struct packed {
        logic [hActiveBits-1:0] column;
        logic [scaleFractionBits-1:0] fraction;
    } sourceCoord;

    typedef struct packed {
        pixelWord leftColor;
        pixelWord rightColor;
        logic [hActiveBits-1:0] leftColumn;
        logic [hActiveBits-1:0] rightColumn;
        logic windowValid;
        logic reserved;
    } pixelWindow;

    // Linear blend where the fraction weights the right pixel
    function automatic pixelWord blendPixels(
        input pixelWord left,
        input pixelWord right,
        input logic [scaleFractionBits-1:0] fraction
    );
        logic [scaleFractionBits:0] leftWeight;
        logic [10:0] redSum;
        logic [11:0] greenSum;
        logic [10:0] blueSum;
        pixelWord result;
        // Seven bits so that a zero fraction gives the full weight of 64
        leftWeight = 7'd64 - {1'b0, fraction};
        redSum = left.rgb.red * leftWeight + right.rgb.red * fraction;
        greenSum = left.rgb.green * leftWeight + right.rgb.green * fraction;
        blueSum = left.rgb.blue * leftWeight + right.rgb.blue * fraction;
        // Dropping the six weight bits brings each sum back to channel range
        result.rgb.red = redSum[10:6];
        result.rgb.green = greenSum[11:6];
        result.rgb.blue = blueSum[10:6];
        return result;
    endfunction

endpackage

//--- hdl/syncFifo.sv
//####################################################################
// Synchronous FIFO with first-word-fall-through output, built as a
// circular buffer with an occupancy count
//####################################################################
`timescale 1ns/1ps

module syncFifo #(
    parameter int dataWidth = 16,
    parameter int addrWidth = 4
) (
    input logic scalerClock,
    input logic reset,
    input logic writeEnable,
    input logic [dataWidth-1:0] writeData,
    input logic readEnable,
    output logic full,
    output logic empty,
    output logic [dataWidth-1:0] readData
);
    localparam int depth = 1 << addrWidth;

    logic [dataWidth-1:0] storage [depth];
    logic [addrWidth-1:0] writePointer;
    logic [addrWidth-1:0] readPointer;
    logic [addrWidth:0] count;
    logic push;
    logic pop;

    // Count tops out at depth, so its top bit alone marks a full buffer
    assign full = count[addrWidth];
    assign empty = (count == '0);
    assign push = writeEnable && !full;
    assign pop = readEnable && !empty;

    // The head word is always on the output while the FIFO holds data
    assign readData = storage[readPointer];

    always_ff @(posedge scalerClock) begin
        if (push) begin
            storage[writePointer] <= writeData;
        end
    end

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            writePointer <= '0;
            readPointer <= '0;
            count <= '0;
        end else begin
            if (push) begin
                writePointer <= writePointer + 1'b1;
            end
            if (pop) begin
                readPointer <= readPointer + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // The blocks on either side must respect the level flags
    assert property (@(posedge scalerClock) disable iff (reset) writeEnable |-> !full)
        else $error("syncFifo write while full");
    assert property (@(posedge scalerClock) disable iff (reset) readEnable |-> !empty)
        else $error("syncFifo read while empty");

endmodule

//--- hdl/upstreamPixelTracker.sv
//####################################################################
// Upstream pixel tracker: tags incoming pixels with their column and
// holds the left and right pixels of the interpolation window
//####################################################################
`timescale 1ns/1ps

module upstreamPixelTracker
    import stretchPkg::*;
#(
    parameter int chunkBits = 5,
    localparam int chunkNumBits = hActiveBits - chunkBits
) (
    input logic scalerClock,
    input logic reset,
    input logic upstreamPixelWrite,
    input pixelWord upstreamPixelData,
    output logic upstreamPixelFull,
    input logic chunkTagWrite,
    input logic [chunkNumBits-1:0] chunkTag,
    output logic chunkTagFull,
    output logic pixelReady,
    input logic windowAdvance,
    output pixelWindow window
);
    pixelWord headPixel;
    logic pixelEmpty;
    logic [chunkNumBits-1:0] headChunk;
    logic tagEmpty;
    logic tagRead;
    logic [chunkBits-1:0] pixelCount;
    logic rightLoaded;

    // Pixel queue holds two chunks so the upstream side can run ahead
    syncFifo #(
        .dataWidth($bits(pixelWord)),
        .addrWidth(chunkBits + 1)
    ) pixelQueue (
        .scalerClock(scalerClock),
        .reset(reset),
        .writeEnable(upstreamPixelWrite),
        .writeData(upstreamPixelData),
        .readEnable(windowAdvance),
        .full(upstreamPixelFull),
        .empty(pixelEmpty),
        .readData(headPixel)
    );

    // Chunk numbers of issued requests, in the order their pixels arrive
    syncFifo #(
        .dataWidth(chunkNumBits),
        .addrWidth(chunkNumBits)
    ) pendingChunkQueue (
        .scalerClock(scalerClock),
        .reset(reset),
        .writeEnable(chunkTagWrite),
        .writeData(chunkTag),
        .readEnable(tagRead),
        .full(chunkTagFull),
        .empty(tagEmpty),
        .readData(headChunk)
    );

    // A pixel is only usable once the chunk it belongs to is known
    assign pixelReady = !pixelEmpty && !tagEmpty;

    // The tag retires with the last pixel of its chunk
    assign tagRead = windowAdvance && (&pixelCount);

    always_ff @(posedge scalerClock or posedge reset) begin
        if (reset) begin
            window <= '0;
            pixelCount <= '0;
            rightLoaded <= 1'b0;
        end else if (windowAdvance) begin
            // Right slot shifts left and the head pixel enters on the right
            window.leftColor <= window.rightColor;
            window.leftColumn <= window.rightColumn;
            window.rightColor <= headPixel;
            window.rightColumn <= {headChunk, pixelCount};
            // Both slots hold real pixels from the second advance on
            window.windowValid <= rightLoaded;
            rightLoaded <= 1'b1;
            pixelCount <= pixelCount + 1'b1;
        end
    end

    // The interpolation stage may only consume a tagged pixel
    assert property (@(posedge scalerClock) disable iff (reset) windowAdvance |-> pixelReady)
        else $error("windowAdvance without a ready pixel");

endmodule

//--- hdl/videoHorizontalStretch.sv
//####################################################################
// Horizontal video scaler top level: request mapping, upstream pixel
// tracking and interpolation joined by FIFO strobes
//####################################################################
`timescale 1ns/1ps

module videoHorizontalStretch
    import stretchPkg::*;
#(
    parameter int chunkBits = 5,
    localparam int chunkNumBits = hActiveBits - chunkBits,
    localparam int requestBits = vActiveBits + chunkNumBits
) (
    input logic scalerClock,
    input logic reset,
    input logic [scaleBits-1:0] hShrinkFactor,
    input logic downstreamRequestEmpty,
    input logic [requestBits-1:0] downstreamRequestData,
    output logic downstreamRequestRead,
    output logic responseWrite,
    output pixelWord responseData,
    input logic responseFull,
    input logic upstreamRequestRead,
    output logic upstreamRequestEmpty,
    output logic [requestBits-1:0] upstreamRequestData,
    input logic upstreamPixelWrite,
    input pixelWord upstreamPixelData,
    output logic upstreamPixelFull
);
    logic chunkTagWrite;
    logic [chunkNumBits-1:0] chunkTag;
    logic chunkTagFull;
    logic coordWrite;
    sourceCoord coord;
    logic coordFull;
    pixelWindow window;
    logic pixelReady;
    logic windowAdvance;

    chunkRequestMapper #(.chunkBits(chunkBits)) mapper (
        .scalerClock(scalerClock),
        .reset(reset),
        .hShrinkFactor(hShrinkFactor),
        .downstreamRequestEmpty(downstreamRequestEmpty),
        .downstreamRequestData(downstreamRequestData),
        .downstreamRequestRead(downstreamRequestRead),
        .upstreamRequestRead(upstreamRequestRead),
        .upstreamRequestEmpty(upstreamRequestEmpty),
        .upstreamRequestData(upstreamRequestData),
        .chunkTagWrite(chunkTagWrite),
        .chunkTag(chunkTag),
        .chunkTagFull(chunkTagFull),
        .coordWrite(coordWrite),
        .coord(coord),
        .coordFull(coordFull)
    );

    upstreamPixelTracker #(.chunkBits(chunkBits)) tracker (
        .scalerClock(scalerClock),
        .reset(reset),
        .upstreamPixelWrite(upstreamPixelWrite),
        .upstreamPixelData(upstreamPixelData),
        .upstreamPixelFull(upstreamPixelFull),
        .chunkTagWrite(chunkTagWrite),
        .chunkTag(chunkTag),
        .chunkTagFull(chunkTagFull),
        .pixelReady(pixelReady),
        .windowAdvance(windowAdvance),
        .window(window)
    );

    interpolationStage interpolator (
        .scalerClock(scalerClock),
        .reset(reset),
        .coordWrite(coordWrite),
        .coord(coord),
        .coordFull(coordFull),
        .window(window),
        .pixelReady(pixelReady),
        .windowAdvance(windowAdvance),
        .responseFull(responseFull),
        .responseWrite(responseWrite),
        .responseData(responseData)
    );

endmodule

//--- tests/stretchTb.sv
//####################################################################
// Horizontal scaler testbench: table of chunk requests, an upstream
// source model and a reference RGB565 blend for every output column
//####################################################################
`timescale 1ns/1ps

module stretchTb
    import stretchPkg::*;
();
    localparam int chunkBits = 3;
    localparam int chunkNumBits = hActiveBits - chunkBits;
    localparam int requestBits = vActiveBits + chunkNumBits;
    localparam int chunkPixels = 1 << chunkBits;
    localparam int testCount = 4;

    // One table row is one test: shrink, row, first chunk, chunk count, full pattern
    typedef struct packed {
        logic [scaleBits-1:0] shrink;
        logic [vActiveBits-1:0] row;
        logic [chunkNumBits-1:0] firstChunk;
        logic [3:0] chunkCount;
        logic [7:0] fullPattern;
    } testEntry;

    // Identity step, half step, non-dyadic step over four chunks, half step under back-pressure
    testEntry testTable [testCount] = '{
        {7'd64, 11'd5, 8'd0, 4'd2, 8'h00},
        {7'd32, 11'd9, 8'd0, 4'd2, 8'h00},
        {7'd48, 11'd17, 8'd1, 4'd4, 8'h00},
        {7'd32, 11'd9, 8'd0, 4'd2, 8'b0110_1101}
    };

    logic scalerClock;
    logic reset;
    logic [scaleBits-1:0] hShrinkFactor;
    logic downstreamRequestEmpty;
    logic [requestBits-1:0] downstreamRequestData;
    logic downstreamRequestRead;
    logic responseWrite;
    logic [15:0] responseData;
    logic responseFull;
    logic upstreamRequestRead;
    logic upstreamRequestEmpty;
    logic [requestBits-1:0] upstreamRequestData;
    logic upstreamPixelWrite;
    logic [15:0] upstreamPixelData;
    logic upstreamPixelFull;

    logic [15:0] colorTable [64];
    logic [requestBits-1:0] pendingRequests [$];
    logic [requestBits-1:0] expectedRequests [$];
    logic [15:0] expectedPixels [$];
    logic [15:0] expectedWord;
    logic [scaleBits-1:0] activeShrink;
    logic [7:0] activePattern;
    int cycleCount;
    int cycleLimit;
    int errorCount;
    int checkCount;
    int receivedCount;
    int pixelsLeft;
    int sendColumn;

    videoHorizontalStretch #(.chunkBits(chunkBits)) dut (
        .scalerClock(scalerClock),
        .reset(reset),
        .hShrinkFactor(hShrinkFactor),
        .downstreamRequestEmpty(downstreamRequestEmpty),
        .downstreamRequestData(downstreamRequestData),
        .downstreamRequestRead(downstreamRequestRead),
        .responseWrite(responseWrite),
        .responseData(responseData),
        .responseFull(responseFull),
        .upstreamRequestRead(upstreamRequestRead),
        .upstreamRequestEmpty(upstreamRequestEmpty),
        .upstreamRequestData(upstreamRequestData),
        .upstreamPixelWrite(upstreamPixelWrite),
        .upstreamPixelData(upstreamPixelData),
        .upstreamPixelFull(upstreamPixelFull)
    );

    always #4 scalerClock = ~scalerClock;

    // Fibonacci LFSR over x^16 + x^14 + x^13 + x^11 + 1, one new bit per step
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // Upstream colour depends only on the column, so repeated chunks carry identical pixels
    function automatic logic [15:0] sourceColor(input int column);
        return colorTable[column % 64];
    endfunction

    function automatic int weighChannel(input int left, input int right, input int fraction);
        return (left * (64 - fraction) + right * fraction) / 64;
    endfunction

    // Reference blend of the two source pixels around a 6-bit fixed-point position
    function automatic logic [15:0] referencePixel(input int position);
        logic [15:0] left;
        logic [15:0] right;
        int fraction;
        int red;
        int green;
        int blue;
        fraction = position % 64;
        left = sourceColor(position / 64);
        right = sourceColor(position / 64 + 1);
        red = weighChannel(left[15:11], right[15:11], fraction);
        green = weighChannel(left[10:5], right[10:5], fraction);
        blue = weighChannel(left[4:0], right[4:0], fraction);
        return {red[4:0], green[5:0], blue[4:0]};
    endfunction

    function automatic bit recentlyIssued(input logic [requestBits-1:0] request,
        input logic [requestBits-1:0] newest, input bit newestValid,
        input logic [requestBits-1:0] older, input bit olderValid);
        return (newestValid && newest == request) || (olderValid && older == request);
    endfunction

    task automatic fillColorTable();
        logic [15:0] lfsrState;
        logic [15:0] colorWord;
        lfsrState = 16'd55;
        colorWord = '0;
        for (int i = 0; i < 64; i++) begin
            // Sixteen steps per pixel, one bit taken from each
            for (int b = 0; b < 16; b++) begin
                lfsrState = lfsrStep(lfsrState);
                colorWord = {colorWord[14:0], lfsrState[0]};
            end
            colorTable[i] = colorWord;
        end
    endtask

    // Queue the downstream requests with the outputs and upstream requests they should cause
    task automatic planTest(input testEntry entry);
        logic [requestBits-1:0] lastRequest;
        logic [requestBits-1:0] previousRequest;
        logic [requestBits-1:0] thisRequest;
        logic [requestBits-1:0] nextRequest;
        bit lastValid;
        bit previousValid;
        int position;
        int column;
        for (int d = 0; d < entry.chunkCount; d++) begin
            pendingRequests.push_back({entry.row, chunkNumBits'(entry.firstChunk + d)});
            // Request memory only filters within one downstream chunk
            lastValid = 0;
            previousValid = 0;
            lastRequest = '0;
            previousRequest = '0;
            for (int p = 0; p < chunkPixels; p++) begin
                column = (entry.firstChunk + d) * chunkPixels + p;
                position = column * entry.shrink + entry.shrink / 2;
                expectedPixels.push_back(referencePixel(position));
                thisRequest = {entry.row, chunkNumBits'(position / 64 / chunkPixels)};
                nextRequest = {entry.row, chunkNumBits'(position / 64 / chunkPixels + 1)};
                if (!recentlyIssued(thisRequest, lastRequest, lastValid,
                    previousRequest, previousValid)) begin
                    expectedRequests.push_back(thisRequest);
                    previousRequest = lastRequest;
                    previousValid = lastValid;
                    lastRequest = thisRequest;
                    lastValid = 1;
                end else if (position % 64 != 0 && (position / 64) % chunkPixels == chunkPixels - 1
                    && !recentlyIssued(nextRequest, lastRequest, lastValid,
                    previousRequest, previousValid)) begin
                    expectedRequests.push_back(nextRequest);
                    previousRequest = lastRequest;
                    previousValid = lastValid;
                    lastRequest = nextRequest;
                    lastValid = 1;
                end
            end
        end
    endtask

    task automatic compareRequest(input logic [requestBits-1:0] actual);
        logic [requestBits-1:0] expected;
        checkCount++;
        if (expectedRequests.size() == 0) begin
            errorCount++;
            $display("Upstream request %h issued when none was expected", actual);
        end else begin
            expected = expectedRequests.pop_front();
            if (actual !== expected) begin
                errorCount++;
                $display("MISMATCH upstreamRequestData: expected %h, got %h", expected, actual);
            end
        end
    endtask

    // Nothing may move before the first downstream request is given
    task automatic checkQuietAfterReset();
        int startErrors;
        startErrors = errorCount;
        repeat (12) begin
            @(negedge scalerClock);
            checkCount++;
            if (responseWrite !== 1'b0) begin
                errorCount++;
                $display("responseWrite went high before any request was given");
            end
            if (downstreamRequestRead !== 1'b0) begin
                errorCount++;
                $display("downstreamRequestRead went high with the request FIFO empty");
            end
            if (upstreamRequestEmpty !== 1'b1) begin
                errorCount++;
                $display("upstreamRequestEmpty dropped before any request was given");
            end
            if (upstreamPixelFull !== 1'b0) begin
                errorCount++;
                $display("upstreamPixelFull went high after reset");
            end
        end
        $display("Test reset: idle strobes, %0d errors", errorCount - startErrors);
    endtask

    task automatic runTest(input int index);
        testEntry entry;
        int target;
        int startErrors;
        entry = testTable[index];
        startErrors = errorCount;
        @(negedge scalerClock);
        activeShrink = entry.shrink;
        activePattern = entry.fullPattern;
        receivedCount = 0;
        target = chunkPixels * entry.chunkCount;
        planTest(entry);
        // The cycle counter ends the run if the outputs never all arrive
        while (receivedCount < target) begin
            @(negedge scalerClock);
        end
        activePattern = 8'h00;
        $display("Test %0d shrink %0d row %0d chunks %0d: %0d outputs, %0d errors",
            index + 1, entry.shrink, entry.row, entry.chunkCount, receivedCount,
            errorCount - startErrors);
    endtask

    // Shrink factor and the back-pressure pattern of the running test
    always @(posedge scalerClock) begin
        hShrinkFactor <= activeShrink;
        responseFull <= activePattern[cycleCount % 8];
    end

    // Downstream request FIFO model with the head word valid while not empty
    always @(posedge scalerClock) begin
        if (downstreamRequestRead && pendingRequests.size() > 0) begin
            pendingRequests.delete(0);
        end
        if (pendingRequests.size() > 0) begin
            downstreamRequestEmpty <= 1'b0;
            downstreamRequestData <= pendingRequests[0];
        end else begin
            downstreamRequestEmpty <= 1'b1;
        end
    end

    // Upstream source pops one request and sends its eight pixels, at most every other cycle
    always @(posedge scalerClock) begin
        upstreamRequestRead <= 1'b0;
        upstreamPixelWrite <= 1'b0;
        if (reset) begin
            pixelsLeft = 0;
        end else if (pixelsLeft == 0) begin
            if (!upstreamRequestEmpty) begin
                upstreamRequestRead <= 1'b1;
                sendColumn = upstreamRequestData[chunkNumBits-1:0] * chunkPixels;
                pixelsLeft = chunkPixels;
                compareRequest(upstreamRequestData);
            end
        end else if (!upstreamPixelFull && !upstreamPixelWrite) begin
            upstreamPixelWrite <= 1'b1;
            upstreamPixelData <= sourceColor(sendColumn);
            sendColumn++;
            pixelsLeft--;
        end
    end

    // Output words are taken in the middle of the cycle, ahead of the edge that moves them
    always @(negedge scalerClock) begin
        if (!reset && responseWrite) begin
            checkCount++;
            if (responseFull) begin
                errorCount++;
                $display("responseWrite was high while responseFull was high");
            end
            if (expectedPixels.size() == 0) begin
                errorCount++;
                $display("Output word %h arrived when none was expected", responseData);
            end else begin
                expectedWord = expectedPixels.pop_front();
                if (responseData !== expectedWord) begin
                    errorCount++;
                    $display("MISMATCH responseData: expected %h, got %h (output %0d)",
                        expectedWord, responseData, receivedCount);
                end
            end
            receivedCount++;
        end
    end

    always @(posedge scalerClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with outputs still missing", cycleLimit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        scalerClock = 1'b0;
        reset = 1'b1;
        hShrinkFactor = 7'd64;
        downstreamRequestEmpty = 1'b1;
        downstreamRequestData = '0;
        responseFull = 1'b0;
        upstreamRequestRead = 1'b0;
        upstreamPixelWrite = 1'b0;
        upstreamPixelData = '0;
        activeShrink = 7'd64;
        activePattern = 8'h00;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        receivedCount = 0;
        pixelsLeft = 0;
        sendColumn = 0;
        fillColorTable();
        // Forty cycles per output pixel plus a fixed margin for reset and drain
        cycleLimit = 200;
        for (int i = 0; i < testCount; i++) begin
            cycleLimit += 40 * chunkPixels * testTable[i].chunkCount;
        end
        repeat (3) @(posedge scalerClock);
        reset <= 1'b0;
        checkQuietAfterReset();
        for (int i = 0; i < testCount; i++) begin
            runTest(i);
        end
        // The last request of the final test feeds its last output, so all are popped by now
        checkCount++;
        if (expectedRequests.size() != 0) begin
            errorCount++;
            $display("%0d expected upstream requests were never issued",
                expectedRequests.size());
        end
        $display("Finished %0d tests: %0d checks, %0d errors", testCount + 1, checkCount,
            errorCount);
        if (errorCount == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
